/* source/sha512_consts.svh */
// SHA-512 accelerator constants for widths, round count, register map and identity
`ifndef SHA512_CONSTS_SVH
`define SHA512_CONSTS_SVH

`define SHA512_WORD_W        64
`define SHA512_BUS_W         32
`define SHA512_BLOCK_W       1024
`define SHA512_BLOCK_WORDS   32
`define SHA512_DIGEST_WORDS  16
`define SHA384_DIGEST_WORDS  12
`define SHA512_ROUNDS        80
`define SHA512_ADDR_W        12

// Identity words, ASCII "sha2" and "512 "
`define SHA512_NAME0         32'h73686132
`define SHA512_NAME1         32'h35313220
`define SHA512_VERSION0      32'h00010000
`define SHA512_VERSION1      32'h00000000

// ------------------------------
// Register offsets
// ------------------------------
`define SHA512_ADDR_NAME     12'h000
`define SHA512_ADDR_VERSION  12'h008
`define SHA512_ADDR_CTRL     12'h010
`define SHA512_ADDR_STATUS   12'h018
`define SHA512_ADDR_INTR_EN  12'h020
`define SHA512_ADDR_INTR_STS 12'h024
`define SHA512_ADDR_BLOCK    12'h080
`define SHA512_ADDR_DIGEST   12'h100

`endif

/* source/sha512_pkg.sv */
// SHA-512 types, round constants and initial hash values
`include "sha512_consts.svh"

package sha512_pkg;

  typedef logic [`SHA512_WORD_W-1:0]  word_t;
  typedef logic [`SHA512_BUS_W-1:0]   bus_word_t;
  // Bus word 0 sits in the top 32 bits
  typedef logic [`SHA512_BLOCK_W-1:0] block_t;
  // Element 0 is a (or H0), element 7 is h (or H7)
  typedef word_t [0:7]                state_t;
  typedef logic [6:0]                 round_idx_t;

  // ------------------------------
  // Round constants
  // ------------------------------
  localparam word_t K_TABLE [0:`SHA512_ROUNDS-1] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // ------------------------------
  // Initial hash values
  // ------------------------------
  localparam state_t IV_512 = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  localparam state_t IV_384 = {
    64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507, 64'h9159015a3070dd17, 64'h152fecd8f70e5939,
    64'h67332667ffc00b31, 64'h8eb44a8768581511, 64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4
  };

  function automatic word_t sha512_k(input round_idx_t idx);
    return K_TABLE[idx];
  endfunction

  function automatic state_t sha512_iv(input logic mode_384);
    return mode_384 ? IV_384 : IV_512;
  endfunction

endpackage

/* source/sha512_core_if.sv */
// Command, block and digest signals between the register block and the hash core
interface sha512_core_if;

  // Driven by the register block
  logic                init;
  logic                next;
  logic                mode_384;
  logic                zeroize;
  sha512_pkg::block_t  block;

  // Driven by the core
  logic                ready;
  logic                digest_valid;
  sha512_pkg::state_t  digest;

  modport regs (
    output init, next, mode_384, zeroize, block,
    input  ready, digest_valid, digest
  );

  modport core (
    input  init, next, mode_384, zeroize, block,
    output ready, digest_valid, digest
  );

endinterface

/* source/sha512_w_mem.sv */
// SHA-512 message schedule with a sliding window of 16 words
`include "sha512_consts.svh"

module sha512_w_mem (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               load,
  input  logic               advance,
  input  sha512_pkg::block_t block,
  output sha512_pkg::word_t  w
);

  localparam int WIN = `SHA512_BLOCK_W / `SHA512_WORD_W;

  // Window holds W[t] .. W[t+15] during round t
  sha512_pkg::word_t win_q [0:WIN-1];
  sha512_pkg::word_t w_new;

  function automatic sha512_pkg::word_t small_sigma0(input sha512_pkg::word_t x);
    return {x[0], x[63:1]} ^ {x[7:0], x[63:8]} ^ (x >> 7);
  endfunction

  function automatic sha512_pkg::word_t small_sigma1(input sha512_pkg::word_t x);
    return {x[18:0], x[63:19]} ^ {x[60:0], x[63:61]} ^ (x >> 6);
  endfunction

  assign w_new = small_sigma1(win_q[14]) + win_q[9] + small_sigma0(win_q[1]) + win_q[0];
  assign w     = win_q[0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < WIN; i++) begin
        win_q[i] <= '0;
      end
    end else if (load) begin
      for (int i = 0; i < WIN; i++) begin
        win_q[i] <= block[`SHA512_BLOCK_W-1-`SHA512_WORD_W*i -: `SHA512_WORD_W];
      end
    end else if (advance) begin
      // Shift down and append the next schedule word
      for (int i = 0; i < WIN-1; i++) begin
        win_q[i] <= win_q[i+1];
      end
      win_q[WIN-1] <= w_new;
    end
  end

endmodule

/* source/sha512_core.sv */
// SHA-512 compression engine running one round per clock
`include "sha512_consts.svh"

module sha512_core (
  input logic         clk,
  input logic         reset_n,
  sha512_core_if.core cif
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ROUND,
    ST_FINAL
  } state_e;

  localparam sha512_pkg::round_idx_t LAST_ROUND =
    sha512_pkg::round_idx_t'(`SHA512_ROUNDS - 1);

  state_e                 state_q;
  sha512_pkg::state_t     h_q;
  sha512_pkg::state_t     v_q;
  sha512_pkg::state_t     v_next;
  sha512_pkg::round_idx_t round_q;
  logic                   valid_q;
  logic                   accept;
  sha512_pkg::word_t      w;

  function automatic sha512_pkg::word_t big_sigma0(input sha512_pkg::word_t x);
    return {x[27:0], x[63:28]} ^ {x[33:0], x[63:34]} ^ {x[38:0], x[63:39]};
  endfunction

  function automatic sha512_pkg::word_t big_sigma1(input sha512_pkg::word_t x);
    return {x[13:0], x[63:14]} ^ {x[17:0], x[63:18]} ^ {x[40:0], x[63:41]};
  endfunction

  // Commands only count while idle
  assign accept = (state_q == ST_IDLE) & (cif.init | cif.next) & ~cif.zeroize;

  // Zeroize reloads the window with an all-zero block
  sha512_w_mem u_w_mem (
    .clk     (clk),
    .reset_n (reset_n),
    .load    (accept | cif.zeroize),
    .advance (state_q == ST_ROUND),
    .block   (cif.zeroize ? '0 : cif.block),
    .w       (w)
  );

  // ------------------------------
  // One compression round
  // ------------------------------
  always_comb begin : round_logic
    sha512_pkg::word_t t1;
    sha512_pkg::word_t t2;
    sha512_pkg::word_t ch;
    sha512_pkg::word_t maj;
    ch  = (v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6]);
    maj = (v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]);
    t1  = v_q[7] + big_sigma1(v_q[4]) + ch + sha512_pkg::sha512_k(round_q) + w;
    t2  = big_sigma0(v_q[0]) + maj;
    v_next = {t1 + t2, v_q[0], v_q[1], v_q[2], v_q[3] + t1, v_q[4], v_q[5], v_q[6]};
  end

  // ------------------------------
  // Control and state
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= ST_IDLE;
      h_q     <= '0;
      v_q     <= '0;
      round_q <= '0;
      valid_q <= 1'b0;
    end else if (cif.zeroize) begin
      state_q <= ST_IDLE;
      h_q     <= '0;
      v_q     <= '0;
      round_q <= '0;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            valid_q <= 1'b0;
            round_q <= '0;
            state_q <= ST_ROUND;
            // init wins if both commands arrive together
            if (cif.init) begin
              h_q <= sha512_pkg::sha512_iv(cif.mode_384);
              v_q <= sha512_pkg::sha512_iv(cif.mode_384);
            end else begin
              v_q <= h_q;
            end
          end
        end
        ST_ROUND: begin
          v_q     <= v_next;
          round_q <= round_q + 1'b1;
          if (round_q == LAST_ROUND) begin
            state_q <= ST_FINAL;
          end
        end
        default: begin
          // Fold the working variables into the chaining value
          for (int i = 0; i < 8; i++) begin
            h_q[i] <= h_q[i] + v_q[i];
          end
          valid_q <= 1'b1;
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign cif.ready        = (state_q == ST_IDLE);
  assign cif.digest_valid = valid_q;
  assign cif.digest       = h_q;

endmodule

/* source/sha512_regs.sv */
// APB register block for the SHA-512 accelerator with command pulses and interrupt
`include "sha512_consts.svh"

module sha512_regs (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`SHA512_ADDR_W-1:0] paddr,
  input  sha512_pkg::bus_word_t     pwdata,
  output sha512_pkg::bus_word_t     prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      notif_intr,
  sha512_core_if.regs               cif
);

  localparam int BLK_IDX_W = $clog2(`SHA512_BLOCK_WORDS);
  localparam int DIG_IDX_W = $clog2(`SHA512_DIGEST_WORDS);

  sha512_pkg::bus_word_t     block_q [0:`SHA512_BLOCK_WORDS-1];
  logic                      init_q, next_q, zeroize_q, mode_q;
  logic                      intr_en_q, intr_sts_q, valid_q;
  logic                      access, wr_en, done_rise;
  logic [`SHA512_ADDR_W-1:0] word_addr, blk_off, dig_off;
  logic [BLK_IDX_W-1:0]      blk_idx;
  logic [DIG_IDX_W-1:0]      dig_idx;
  logic                      blk_hit, dig_hit, addr_ok, addr_ro;
  sha512_pkg::bus_word_t     rd_data, dig_word;
  sha512_pkg::word_t         dig_pair;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign access    = psel & penable;
  assign word_addr = {paddr[`SHA512_ADDR_W-1:2], 2'b00};
  assign blk_off   = word_addr - `SHA512_ADDR_BLOCK;
  assign dig_off   = word_addr - `SHA512_ADDR_DIGEST;
  assign blk_idx   = blk_off[BLK_IDX_W+1:2];
  assign dig_idx   = dig_off[DIG_IDX_W+1:2];
  assign blk_hit   = (word_addr >= `SHA512_ADDR_BLOCK) && (blk_off < 4 * `SHA512_BLOCK_WORDS);
  assign dig_hit   = (word_addr >= `SHA512_ADDR_DIGEST) && (dig_off < 4 * `SHA512_DIGEST_WORDS);

  // Digest is big endian, upper half of each hash word first
  always_comb begin
    dig_pair = cif.digest[dig_idx[DIG_IDX_W-1:1]];
    dig_word = dig_idx[0] ? dig_pair[31:0] : dig_pair[63:32];
    if (mode_q && (dig_idx >= `SHA384_DIGEST_WORDS)) begin
      dig_word = '0;
    end
  end

  always_comb begin
    rd_data = '0;
    addr_ok = 1'b1;
    addr_ro = 1'b0;
    if (blk_hit) begin
      rd_data = block_q[blk_idx];
    end else if (dig_hit) begin
      rd_data = dig_word;
      addr_ro = 1'b1;
    end else begin
      case (word_addr)
        `SHA512_ADDR_NAME: begin
          rd_data = `SHA512_NAME0;
          addr_ro = 1'b1;
        end
        `SHA512_ADDR_NAME + 12'h4: begin
          rd_data = `SHA512_NAME1;
          addr_ro = 1'b1;
        end
        `SHA512_ADDR_VERSION: begin
          rd_data = `SHA512_VERSION0;
          addr_ro = 1'b1;
        end
        `SHA512_ADDR_VERSION + 12'h4: begin
          rd_data = `SHA512_VERSION1;
          addr_ro = 1'b1;
        end
        `SHA512_ADDR_CTRL:     rd_data[2] = mode_q;
        `SHA512_ADDR_STATUS: begin
          rd_data[1:0] = {cif.digest_valid, cif.ready};
          addr_ro      = 1'b1;
        end
        `SHA512_ADDR_INTR_EN:  rd_data[0] = intr_en_q;
        `SHA512_ADDR_INTR_STS: rd_data[0] = intr_sts_q;
        default:               addr_ok = 1'b0;
      endcase
    end
  end

  assign prdata  = rd_data;
  assign pready  = 1'b1;
  assign pslverr = access & (~addr_ok | (pwrite & addr_ro));
  assign wr_en   = access & pwrite & addr_ok & ~addr_ro;

  // ------------------------------
  // Control, mode and interrupt
  // ------------------------------
  assign done_rise = cif.digest_valid & ~valid_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_q     <= 1'b0;
      next_q     <= 1'b0;
      zeroize_q  <= 1'b0;
      mode_q     <= 1'b0;
      intr_en_q  <= 1'b0;
      intr_sts_q <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      // Command bits live for one cycle only
      init_q    <= wr_en & (word_addr == `SHA512_ADDR_CTRL) & pwdata[0];
      next_q    <= wr_en & (word_addr == `SHA512_ADDR_CTRL) & pwdata[1];
      zeroize_q <= wr_en & (word_addr == `SHA512_ADDR_CTRL) & pwdata[4];
      if (wr_en && (word_addr == `SHA512_ADDR_CTRL)) begin
        mode_q <= pwdata[2];
      end
      if (wr_en && (word_addr == `SHA512_ADDR_INTR_EN)) begin
        intr_en_q <= pwdata[0];
      end
      // A new completion beats a simultaneous clear
      intr_sts_q <= done_rise | (intr_sts_q &
                    ~(wr_en & (word_addr == `SHA512_ADDR_INTR_STS) & pwdata[0]));
      valid_q    <= cif.digest_valid;
    end
  end

  assign notif_intr = intr_sts_q & intr_en_q;

  // Message block words
  always_ff @(posedge clk) begin
    if (zeroize_q) begin
      for (int i = 0; i < `SHA512_BLOCK_WORDS; i++) begin
        block_q[i] <= '0;
      end
    end else if (wr_en && blk_hit) begin
      block_q[blk_idx] <= pwdata;
    end
  end

  always_comb begin
    for (int i = 0; i < `SHA512_BLOCK_WORDS; i++) begin
      cif.block[`SHA512_BLOCK_W-1-`SHA512_BUS_W*i -: `SHA512_BUS_W] = block_q[i];
    end
  end

  assign cif.init     = init_q;
  assign cif.next     = next_q;
  assign cif.zeroize  = zeroize_q;
  assign cif.mode_384 = mode_q;

endmodule

/* source/sha512.sv */
// SHA-512 accelerator top level with APB slave port and completion interrupt
`include "sha512_consts.svh"

module sha512 (
  input  logic                      clk,
  input  logic                      reset_n,

  // APB slave
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`SHA512_ADDR_W-1:0] paddr,
  input  sha512_pkg::bus_word_t     pwdata,
  output sha512_pkg::bus_word_t     prdata,
  output logic                      pready,
  output logic                      pslverr,

  output logic                      notif_intr
);

  sha512_core_if cif ();

  sha512_regs u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .notif_intr (notif_intr),
    .cif        (cif.regs)
  );

  sha512_core u_core (
    .clk     (clk),
    .reset_n (reset_n),
    .cif     (cif.core)
  );

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock source with an active-low reset held for a fixed number of cycles
module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release just after a rising edge
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
  end

endmodule

/* verification/tb_sha512.sv */
// SHA-512 accelerator testbench with APB driver, reference model and self-checks
`include "sha512_consts.svh"

module tb_sha512;

  // About 12 hashes with their bus traffic
  localparam int MAX_CYCLES = 4000;
  localparam int BW         = `SHA512_BLOCK_WORDS;
  localparam int DW         = `SHA512_DIGEST_WORDS;

  logic                      clk;
  logic                      reset_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [`SHA512_ADDR_W-1:0] paddr;
  sha512_pkg::bus_word_t     pwdata;
  sha512_pkg::bus_word_t     prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      notif_intr;

  int                    error_count = 0;
  int                    check_count = 0;
  int                    cycle_count = 0;
  sha512_pkg::bus_word_t got_digest [0:DW-1];
  sha512_pkg::bus_word_t exp_digest [0:DW-1];
  event                  compare_ev;
  event                  compare_done;

  tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(8)) u_clk_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  sha512 UUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .notif_intr (notif_intr)
  );

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic sha512_pkg::word_t rotr(input sha512_pkg::word_t x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  function automatic sha512_pkg::word_t ssig0(input sha512_pkg::word_t x);
    return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  function automatic sha512_pkg::word_t ssig1(input sha512_pkg::word_t x);
    return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  function automatic sha512_pkg::word_t bsig0(input sha512_pkg::word_t x);
    return rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  function automatic sha512_pkg::word_t bsig1(input sha512_pkg::word_t x);
    return rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  // Hashes one or two raw blocks without adding padding
  function automatic sha512_pkg::state_t sha512_ref(input sha512_pkg::block_t b0,
                                                    input sha512_pkg::block_t b1,
                                                    input int nblk, input logic mode_384);
    sha512_pkg::state_t h;
    sha512_pkg::state_t v;
    sha512_pkg::block_t blk;
    sha512_pkg::word_t  w [0:79];
    sha512_pkg::word_t  t1;
    sha512_pkg::word_t  t2;
    h = sha512_pkg::sha512_iv(mode_384);
    for (int n = 0; n < nblk; n++) begin
      blk = (n == 0) ? b0 : b1;
      for (int t = 0; t < 16; t++) begin
        w[t] = blk[`SHA512_BLOCK_W-1-64*t -: 64];
      end
      for (int t = 16; t < 80; t++) begin
        w[t] = ssig1(w[t-2]) + w[t-7] + ssig0(w[t-15]) + w[t-16];
      end
      v = h;
      for (int t = 0; t < 80; t++) begin
        t1 = v[7] + bsig1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6]))
             + sha512_pkg::sha512_k(sha512_pkg::round_idx_t'(t)) + w[t];
        t2 = bsig0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        v  = {t1 + t2, v[0], v[1], v[2], v[3] + t1, v[4], v[5], v[6]};
      end
      for (int i = 0; i < 8; i++) begin
        h[i] = h[i] + v[i];
      end
    end
    return h;
  endfunction

  function automatic sha512_pkg::block_t random_block();
    sha512_pkg::block_t blk;
    for (int i = 0; i < BW; i++) begin
      blk[`SHA512_BLOCK_W-1-32*i -: 32] = $urandom;
    end
    return blk;
  endfunction

  // Split hash words into bus words with the upper half first
  task automatic set_expected(input sha512_pkg::state_t h, input logic mode_384);
    for (int i = 0; i < DW; i++) begin
      exp_digest[i] = (i % 2) ? h[i/2][31:0] : h[i/2][63:32];
      if (mode_384 && i >= `SHA384_DIGEST_WORDS) begin
        exp_digest[i] = '0;
      end
    end
  endtask

  // ------------------------------
  // Checking
  // ------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  always begin : digest_compare
    @(compare_ev);
    for (int i = 0; i < DW; i++) begin
      check_value($sformatf("digest[%0d]", i), got_digest[i], exp_digest[i]);
    end
    -> compare_done;
  end

  task automatic compare_digest();
    -> compare_ev;
    @(compare_done);
  endtask

  // ------------------------------
  // APB driver
  // ------------------------------
  task automatic apb_write(input logic [`SHA512_ADDR_W-1:0] addr,
                           input sha512_pkg::bus_word_t data, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    err = pslverr;
    check_value("pready", pready, 1'b1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`SHA512_ADDR_W-1:0] addr,
                          output sha512_pkg::bus_word_t data, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // Mid-cycle sample of the access phase
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check_value("pready", pready, 1'b1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_block(input sha512_pkg::block_t blk);
    logic err;
    for (int i = 0; i < BW; i++) begin
      apb_write(`SHA512_ADDR_BLOCK + 4 * i, blk[`SHA512_BLOCK_W-1-32*i -: 32], err);
    end
  endtask

  task automatic read_digest();
    sha512_pkg::bus_word_t rd;
    logic                  err;
    for (int i = 0; i < DW; i++) begin
      apb_read(`SHA512_ADDR_DIGEST + 4 * i, rd, err);
      got_digest[i] = rd;
    end
  endtask

  // Poll STATUS until the digest is valid
  task automatic wait_digest_valid();
    sha512_pkg::bus_word_t rd;
    logic                  err;
    rd = '0;
    while (!rd[1]) begin
      apb_read(`SHA512_ADDR_STATUS, rd, err);
    end
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin : watchdog
    wait (cycle_count >= MAX_CYCLES);
    $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main
    sha512_pkg::block_t    blk_a;
    sha512_pkg::block_t    blk_b;
    sha512_pkg::state_t    ref_h;
    sha512_pkg::bus_word_t rd;
    logic                  err;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    void'($urandom(32'h4a51));
    wait (reset_n === 1'b1);

    // Identity and reset state
    apb_read(`SHA512_ADDR_NAME, rd, err);
    check_value("name0", rd, `SHA512_NAME0);
    check_value("pslverr", err, 1'b0);
    apb_read(`SHA512_ADDR_NAME + 4, rd, err);
    check_value("name1", rd, `SHA512_NAME1);
    apb_read(`SHA512_ADDR_VERSION, rd, err);
    check_value("version0", rd, `SHA512_VERSION0);
    apb_read(`SHA512_ADDR_VERSION + 4, rd, err);
    check_value("version1", rd, `SHA512_VERSION1);
    apb_read(`SHA512_ADDR_STATUS, rd, err);
    check_value("status", rd, 32'h1);
    read_digest();
    set_expected('0, 1'b0);
    compare_digest();
    check_value("notif_intr", notif_intr, 1'b0);

    // Padded "abc" with SHA-512
    blk_a = '0;
    blk_a[`SHA512_BLOCK_W-1 -: 32] = 32'h61626380;
    blk_a[127:0] = 128'd24;
    write_block(blk_a);
    apb_write(`SHA512_ADDR_CTRL, 32'h1, err);
    wait_digest_valid();
    read_digest();
    ref_h = sha512_ref(blk_a, blk_a, 1, 1'b0);
    check_value("ref_abc_h0", ref_h[0], 64'hddaf35a193617aba);
    check_value("ref_abc_h7", ref_h[7], 64'h2a9ac94fa54ca49f);
    set_expected(ref_h, 1'b0);
    compare_digest();

    // Two random blocks with a NEXT while busy and block writes during the hash
    blk_a = random_block();
    blk_b = random_block();
    write_block(blk_a);
    apb_write(`SHA512_ADDR_CTRL, 32'h1, err);
    apb_read(`SHA512_ADDR_STATUS, rd, err);
    check_value("status.ready", rd[0], 1'b0);
    // A changed first word makes an accepted busy NEXT visible in the digest
    apb_write(`SHA512_ADDR_BLOCK, blk_b[`SHA512_BLOCK_W-1 -: 32], err);
    apb_write(`SHA512_ADDR_CTRL, 32'h2, err);
    write_block(blk_b);
    wait_digest_valid();
    apb_write(`SHA512_ADDR_CTRL, 32'h2, err);
    wait_digest_valid();
    read_digest();
    set_expected(sha512_ref(blk_a, blk_b, 2, 1'b0), 1'b0);
    compare_digest();

    // SHA-384 of a random block
    blk_a = random_block();
    write_block(blk_a);
    apb_write(`SHA512_ADDR_CTRL, 32'h5, err);
    wait_digest_valid();
    read_digest();
    set_expected(sha512_ref(blk_a, blk_a, 1, 1'b1), 1'b1);
    compare_digest();

    // Interrupt enabled and then cleared
    apb_write(`SHA512_ADDR_INTR_STS, 32'h1, err);
    apb_write(`SHA512_ADDR_INTR_EN, 32'h1, err);
    check_value("notif_intr", notif_intr, 1'b0);
    apb_write(`SHA512_ADDR_CTRL, 32'h1, err);
    wait_digest_valid();
    @(negedge clk);
    check_value("notif_intr", notif_intr, 1'b1);
    apb_write(`SHA512_ADDR_INTR_STS, 32'h1, err);
    check_value("notif_intr", notif_intr, 1'b0);

    // Interrupt disabled while the status bit still sets
    apb_write(`SHA512_ADDR_INTR_EN, 32'h0, err);
    apb_write(`SHA512_ADDR_CTRL, 32'h1, err);
    wait_digest_valid();
    @(negedge clk);
    check_value("notif_intr", notif_intr, 1'b0);
    apb_read(`SHA512_ADDR_INTR_STS, rd, err);
    check_value("intr_sts", rd, 32'h1);

    // Zeroize and bus errors
    apb_write(`SHA512_ADDR_CTRL, 32'h10, err);
    apb_read(`SHA512_ADDR_STATUS, rd, err);
    check_value("status", rd, 32'h1);
    read_digest();
    set_expected('0, 1'b0);
    compare_digest();
    for (int i = 0; i < BW; i++) begin
      apb_read(`SHA512_ADDR_BLOCK + 4 * i, rd, err);
      check_value($sformatf("block[%0d]", i), rd, 32'h0);
    end
    apb_read(12'h040, rd, err);
    check_value("pslverr", err, 1'b1);
    apb_write(`SHA512_ADDR_STATUS, 32'h0, err);
    check_value("pslverr", err, 1'b1);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+source
source/sha512_pkg.sv
source/sha512_core_if.sv
source/sha512_w_mem.sv
source/sha512_core.sv
source/sha512_regs.sv
source/sha512.sv
verification/tb_clock_gen.sv
verification/tb_sha512.sv
